// File: verilog.f
hdl/bridge_pkg.sv
hdl/shell_csr.sv
hdl/addr_remap.sv
hdl/mem_profiler.sv
hdl/dram_req_fifo.sv
hdl/zynq_bridge_top.sv
test/tb_clk_gen.sv
test/tb_zynq_bridge.sv

// File: Makefile
TOP = tb_zynq_bridge

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module zynq_bridge_top

clean:
	rm -rf obj_dir sim.log

// File: test/tb_zynq_bridge.sv
module tb_zynq_bridge
   import bridge_pkg::*;
();

   localparam int RESET_CYCLES = 8;
   localparam int HOST_REQS    = 40;
   localparam int DRAM_REQS    = 60;
   localparam int PROF_REQS    = 10;
   localparam int APB_XFERS    = 40;
   // generous cycle budget for one request or register transfer under random stalls
   localparam int REQ_BOUND    = 40;
   localparam int WATCHDOG_CYCLES =
      RESET_CYCLES + (HOST_REQS + DRAM_REQS + PROF_REQS + APB_XFERS) * REQ_BOUND;

   // mix of regions, several of them past the memory limit
   localparam logic [ADDR_W-1:0] PROF_ADDRS [PROF_REQS] = '{
      32'h8000_0000, 32'h8080_0010, 32'h87FF_FFFC, 32'h8780_0000, 32'h9000_0000,
      32'h3F80_0004, 32'h0000_0000, 32'h8400_0000, 32'hA080_0000, 32'h8200_0100
   };

   logic                    clk;
   logic                    arst_n;
   logic [APB_ADDR_W-1:0]   paddr;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [DATA_W-1:0]       pwdata;
   logic [DATA_W-1:0]       prdata;
   logic                    pready;
   logic                    pslverr;
   logic                    host_valid;
   logic [HOST_ADDR_W-1:0]  host_addr;
   logic                    host_ready;
   logic                    core_valid;
   logic [ADDR_W-1:0]       core_addr;
   logic                    core_ready;
   logic                    core_req_valid;
   logic [ADDR_W-1:0]       core_req_addr;
   dram_op_e                core_req_op;
   logic                    core_req_ready;
   logic                    dram_valid;
   logic [ADDR_W-1:0]       dram_addr;
   dram_op_e                dram_op;
   logic                    dram_ready;
   logic                    core_reset;

   integer                  seed;
   int                      errors = 0;
   int                      err_mark = 0;
   int                      tests_run = 0;
   int                      tests_failed = 0;
   logic [ADDR_W-1:0]       cur_base;
   logic [PROF_REGIONS-1:0] exp_prof;
   int                      exp_viol;
   logic [ADDR_W-1:0]       exp_host_q [$];
   logic [ADDR_W-1:0]       exp_dram_addr_q [$];
   dram_op_e                exp_dram_op_q [$];

   tb_clk_gen #(.PERIOD(20)) u_clk_gen (.clk_o(clk));

   zynq_bridge_top #(.FIFO_DEPTH(2), .PROF_REGIONS(PROF_REGIONS)) u_zynq_bridge_top
   (
      .aclk_i            (clk)
      , .arst_n_i        (arst_n)
      , .paddr_i         (paddr)
      , .psel_i          (psel)
      , .penable_i       (penable)
      , .pwrite_i        (pwrite)
      , .pwdata_i        (pwdata)
      , .prdata_o        (prdata)
      , .pready_o        (pready)
      , .pslverr_o       (pslverr)
      , .host_valid_i    (host_valid)
      , .host_addr_i     (host_addr)
      , .host_ready_o    (host_ready)
      , .core_valid_o    (core_valid)
      , .core_addr_o     (core_addr)
      , .core_ready_i    (core_ready)
      , .core_req_valid_i(core_req_valid)
      , .core_req_addr_i (core_req_addr)
      , .core_req_op_i   (core_req_op)
      , .core_req_ready_o(core_req_ready)
      , .dram_valid_o    (dram_valid)
      , .dram_addr_o     (dram_addr)
      , .dram_op_o       (dram_op)
      , .dram_ready_i    (dram_ready)
      , .core_reset_o    (core_reset)
   );

   // host bit 29 picks DRAM or local space and bit 28 is dropped
   function automatic logic [ADDR_W-1:0] host_to_core(input logic [HOST_ADDR_W-1:0] a);
      logic [ADDR_W-1:0] c;
      c = ADDR_W'(a) & 32'h0FFF_FFFF;
      if (a[29] == 1'b0)
         c = c | 32'h8000_0000;
      return c;
   endfunction

   // flipping bit 31 is the same as adding half of the 32-bit space
   function automatic logic [ADDR_W-1:0] rebase(input logic [ADDR_W-1:0] a,
                                                input logic [ADDR_W-1:0] base);
      return a + 32'h8000_0000 + base;
   endfunction

   function automatic int region_of(input logic [ADDR_W-1:0] a);
      return int'(a[29:23]);
   endfunction

   // the host set aside 120 MiB of DRAM for the core
   function automatic bit past_limit(input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] offset;
      offset = a + 32'h8000_0000;
      return offset >= 32'(120 * 1024 * 1024);
   endfunction

   task automatic check(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                        input string what);
      if (actual !== expected)
      begin
         errors++;
         $display("Mismatch at time %0t: %s, got 0x%h, expected 0x%h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic fault(input string what);
      errors++;
      $display("Error at time %0t: %s", $time, what);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != err_mark)
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - err_mark);
      end
      else
         $display("%s: ok", name);
      err_mark = errors;
   endtask

   // setup cycle, then access cycle sampled at its closing rising edge
   task automatic apb_xfer(input logic [APB_ADDR_W-1:0] addr, input logic write,
                           input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                           output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      rdata = prdata;
      err   = pslverr;
      if (pready !== 1'b1)
         fault("APB slave did not complete the transfer without wait states");
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_expect(input logic [APB_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] expected, input string what);
      logic [DATA_W-1:0] data;
      logic              err;
      apb_xfer(addr, 1'b0, '0, data, err);
      check(data, expected, what);
      check(32'(err), 32'd0, {what, " error response"});
   endtask

   task automatic write_expect(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic exp_err, input string what);
      logic [DATA_W-1:0] unused;
      logic              err;
      apb_xfer(addr, 1'b1, data, unused, err);
      check(32'(err), 32'(exp_err), {what, " error response"});
   endtask

   task automatic send_host(input logic [HOST_ADDR_W-1:0] addr);
      logic              accepted;
      logic [DATA_W-1:0] r;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge clk);
         r = $random(seed);
         core_ready = (r[1:0] != 2'b00);
         host_valid = 1'b1;
         host_addr  = addr;
         @(posedge clk);
         if (host_ready)
         begin
            accepted = 1'b1;
            exp_host_q.push_back(host_to_core(addr));
         end
      end
   endtask

   task automatic send_core_req(input logic [ADDR_W-1:0] addr, input dram_op_e op,
                                input logic stall);
      logic              accepted;
      logic [DATA_W-1:0] r;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge clk);
         r = $random(seed);
         dram_ready     = stall ? r[0] : 1'b1;
         core_req_valid = 1'b1;
         core_req_addr  = addr;
         core_req_op    = op;
         @(posedge clk);
         if (core_req_ready)
         begin
            accepted = 1'b1;
            exp_dram_addr_q.push_back(rebase(addr, cur_base));
            exp_dram_op_q.push_back(op);
         end
      end
   endtask

   task automatic drain();
      @(negedge clk);
      host_valid     = 1'b0;
      core_req_valid = 1'b0;
      core_ready     = 1'b1;
      dram_ready     = 1'b1;
      while ((exp_host_q.size() != 0) || (exp_dram_addr_q.size() != 0))
         @(posedge clk);
   endtask

   // every completed output transfer is matched against the oldest expected item
   always @(posedge clk)
   begin
      if (core_valid && core_ready)
      begin
         if (exp_host_q.size() == 0)
            fault("core side output appeared with no host request outstanding");
         else
            check(core_addr, exp_host_q.pop_front(), "translated host address");
      end
      if (dram_valid && dram_ready)
      begin
         if (exp_dram_addr_q.size() == 0)
            fault("DRAM side output appeared with no core request outstanding");
         else
         begin
            check(dram_addr, exp_dram_addr_q.pop_front(), "rebased DRAM address");
            check(32'(dram_op), 32'(exp_dram_op_q.pop_front()), "DRAM opcode");
         end
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin : main
      logic [DATA_W-1:0] rnd;
      logic [DATA_W-1:0] rnd_op;
      logic              err;
      int                k;
      seed           = 4;
      arst_n         = 1'b0;
      paddr          = '0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      pwdata         = '0;
      host_valid     = 1'b0;
      host_addr      = '0;
      core_ready     = 1'b1;
      core_req_valid = 1'b0;
      core_req_addr  = '0;
      core_req_op    = DRAM_RD;
      dram_ready     = 1'b1;
      cur_base       = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;

      @(negedge clk);
      check(32'(core_reset), 32'd1, "core reset after bridge reset");
      check(32'(core_valid), 32'd0, "core valid after reset");
      check(32'(dram_valid), 32'd0, "DRAM valid after reset");
      check(32'(host_ready), 32'd1, "host ready after reset");
      check(32'(core_req_ready), 32'd1, "core request ready after reset");
      check(32'(pslverr), 32'd0, "APB error after reset");
      for (k = 0; k < 8; k++)
         read_expect(APB_ADDR_W'(4 * k), '0, $sformatf("register 0x%0h after reset", 4 * k));
      apb_xfer(6'd36, 1'b0, '0, rnd, err);
      check(32'(err), 32'd1, "error response for unmapped offset");
      finish_test("test 1 reset state");

      write_expect(CSR_ALLOC, 32'd1, 1'b0, "write ALLOC");
      write_expect(CSR_BASE, 32'h1234_5670, 1'b0, "write BASE");
      cur_base = 32'h1234_5670;
      write_expect(CSR_PROF0, 32'hFFFF_FFFF, 1'b1, "write to read-only PROF0");
      read_expect(CSR_PROF0, '0, "PROF0 after rejected write");
      read_expect(CSR_ALLOC, 32'd1, "ALLOC readback");
      read_expect(CSR_BASE, 32'h1234_5670, "BASE readback");
      check(32'(core_reset), 32'd1, "core reset before run bit");
      write_expect(CSR_CTRL, 32'd1, 1'b0, "write CTRL run bit");
      read_expect(CSR_CTRL, 32'd1, "CTRL readback");
      check(32'(core_reset), 32'd0, "core reset with run bit set");
      finish_test("test 2 register access");

      for (k = 0; k < HOST_REQS; k++)
      begin
         rnd = $random(seed);
         send_host(rnd[HOST_ADDR_W-1:0]);
      end
      drain();
      finish_test("test 3 host window");

      rnd = $random(seed);
      write_expect(CSR_BASE, rnd, 1'b0, "write random BASE");
      cur_base = rnd;
      read_expect(CSR_BASE, cur_base, "random BASE readback");
      for (k = 0; k < DRAM_REQS; k++)
      begin
         rnd    = $random(seed);
         rnd_op = $random(seed);
         send_core_req(rnd, dram_op_e'(rnd_op[0]), 1'b1);
      end
      drain();
      finish_test("test 4 DRAM rebase");

      // restarting the core clears the history left by the random requests
      write_expect(CSR_CTRL, 32'd0, 1'b0, "stop core");
      write_expect(CSR_CTRL, 32'd1, 1'b0, "restart core");
      exp_prof = '0;
      exp_viol = 0;
      for (k = 0; k < PROF_REQS; k++)
      begin
         send_core_req(PROF_ADDRS[k], dram_op_e'(k[0]), 1'b0);
         exp_prof[region_of(PROF_ADDRS[k])] = 1'b1;
         if (past_limit(PROF_ADDRS[k]))
            exp_viol++;
      end
      drain();
      for (k = 0; k < 4; k++)
         read_expect(APB_ADDR_W'(int'(CSR_PROF0) + 4 * k), exp_prof[32 * k +: 32],
                     $sformatf("profiler word %0d", k));
      read_expect(CSR_VIOL, 32'(exp_viol), "violation count");
      finish_test("test 5 profiler and violations");

      write_expect(CSR_CTRL, 32'd0, 1'b0, "clear run bit");
      check(32'(core_reset), 32'd1, "core reset after run bit cleared");
      for (k = 0; k < 4; k++)
         read_expect(APB_ADDR_W'(int'(CSR_PROF0) + 4 * k), '0,
                     $sformatf("profiler word %0d while core held", k));
      read_expect(CSR_VIOL, '0, "violation count while core held");
      finish_test("test 6 run bit cleared");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: test/tb_clk_gen.sv
module tb_clk_gen
#(
   parameter int PERIOD = 20
)
(
   output logic clk_o
);

   // free running clock, first rising edge after half a period
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD / 2) clk_o = ~clk_o;
   end

endmodule

// File: hdl/zynq_bridge_top.sv
module zynq_bridge_top
   import bridge_pkg::*;
#(
   parameter int FIFO_DEPTH   = 2
   , parameter int PROF_REGIONS = bridge_pkg::PROF_REGIONS
)
(
   input  logic                     aclk_i
   , input  logic                   arst_n_i
   // host register access
   , input  logic [APB_ADDR_W-1:0]  paddr_i
   , input  logic                   psel_i
   , input  logic                   penable_i
   , input  logic                   pwrite_i
   , input  logic [DATA_W-1:0]      pwdata_i
   , output logic [DATA_W-1:0]      prdata_o
   , output logic                   pready_o
   , output logic                   pslverr_o
   // host window into the core
   , input  logic                   host_valid_i
   , input  logic [HOST_ADDR_W-1:0] host_addr_i
   , output logic                   host_ready_o
   , output logic                   core_valid_o
   , output logic [ADDR_W-1:0]      core_addr_o
   , input  logic                   core_ready_i
   // core DRAM requests out to the host memory
   , input  logic                   core_req_valid_i
   , input  logic [ADDR_W-1:0]      core_req_addr_i
   , input  dram_op_e               core_req_op_i
   , output logic                   core_req_ready_o
   , output logic                   dram_valid_o
   , output logic [ADDR_W-1:0]      dram_addr_o
   , output dram_op_e               dram_op_o
   , input  logic                   dram_ready_i
   , output logic                   core_reset_o
);

   logic [ADDR_W-1:0]       dram_base;
   logic [PROF_REGIONS-1:0] prof_bits;
   logic [DATA_W-1:0]       viol_count;
   logic                    fifo_valid;
   logic [ADDR_W-1:0]       fifo_addr;
   dram_op_e                fifo_op;
   logic                    fifo_ready;
   logic                    req_fire;

   // the profiler watches raw core addresses as they are accepted
   assign req_fire = core_req_valid_i & core_req_ready_o;

   shell_csr #(.PROF_REGIONS(PROF_REGIONS)) u_shell_csr
   (
      .aclk_i        (aclk_i)
      , .arst_n_i    (arst_n_i)
      , .paddr_i     (paddr_i)
      , .psel_i      (psel_i)
      , .penable_i   (penable_i)
      , .pwrite_i    (pwrite_i)
      , .pwdata_i    (pwdata_i)
      , .prdata_o    (prdata_o)
      , .pready_o    (pready_o)
      , .pslverr_o   (pslverr_o)
      , .prof_bits_i (prof_bits)
      , .viol_count_i(viol_count)
      , .dram_base_o (dram_base)
      , .core_reset_o(core_reset_o)
   );

   addr_remap u_addr_remap
   (
      .aclk_i            (aclk_i)
      , .arst_n_i        (arst_n_i)
      , .host_valid_i    (host_valid_i)
      , .host_addr_i     (host_addr_i)
      , .host_ready_o    (host_ready_o)
      , .core_valid_o    (core_valid_o)
      , .core_addr_o     (core_addr_o)
      , .core_ready_i    (core_ready_i)
      , .core_req_valid_i(core_req_valid_i)
      , .core_req_addr_i (core_req_addr_i)
      , .core_req_op_i   (core_req_op_i)
      , .core_req_ready_o(core_req_ready_o)
      , .dram_base_i     (dram_base)
      , .fifo_valid_o    (fifo_valid)
      , .fifo_addr_o     (fifo_addr)
      , .fifo_op_o       (fifo_op)
      , .fifo_ready_i    (fifo_ready)
   );

   mem_profiler #(.PROF_REGIONS(PROF_REGIONS)) u_mem_profiler
   (
      .aclk_i        (aclk_i)
      , .arst_n_i    (arst_n_i)
      , .core_reset_i(core_reset_o)
      , .req_fire_i  (req_fire)
      , .req_addr_i  (core_req_addr_i)
      , .prof_bits_o (prof_bits)
      , .viol_count_o(viol_count)
   );

   dram_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_dram_req_fifo
   (
      .aclk_i       (aclk_i)
      , .arst_n_i   (arst_n_i)
      , .in_valid_i (fifo_valid)
      , .in_addr_i  (fifo_addr)
      , .in_op_i    (fifo_op)
      , .in_ready_o (fifo_ready)
      , .out_valid_o(dram_valid_o)
      , .out_addr_o (dram_addr_o)
      , .out_op_o   (dram_op_o)
      , .out_ready_i(dram_ready_i)
   );

endmodule

// File: hdl/dram_req_fifo.sv
module dram_req_fifo
   import bridge_pkg::*;
#(
   parameter int FIFO_DEPTH = 2
)
(
   input  logic                aclk_i
   , input  logic              arst_n_i
   , input  logic              in_valid_i
   , input  logic [ADDR_W-1:0] in_addr_i
   , input  dram_op_e          in_op_i
   , output logic              in_ready_o
   , output logic              out_valid_o
   , output logic [ADDR_W-1:0] out_addr_o
   , output dram_op_e          out_op_o
   , input  logic              out_ready_i
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];
   dram_op_e          op_mem   [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_r;
   logic [PTR_W-1:0]  rd_ptr_r;
   logic [CNT_W-1:0]  count_r;
   logic              push;
   logic              pop;

   assign in_ready_o  = (count_r != CNT_W'(FIFO_DEPTH));
   assign out_valid_o = (count_r != '0);
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   // pointers wrap explicitly so the depth need not be a power of two
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= (wr_ptr_r == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= (rd_ptr_r == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (push)
      begin
         addr_mem[wr_ptr_r] <= in_addr_i;
         op_mem[wr_ptr_r]   <= in_op_i;
      end
   end

   assign out_addr_o = addr_mem[rd_ptr_r];
   assign out_op_o   = op_mem[rd_ptr_r];

endmodule

// File: hdl/mem_profiler.sv
module mem_profiler
   import bridge_pkg::*;
#(
   parameter int PROF_REGIONS = bridge_pkg::PROF_REGIONS
)
(
   input  logic                      aclk_i
   , input  logic                    arst_n_i
   , input  logic                    core_reset_i
   , input  logic                    req_fire_i
   , input  logic [ADDR_W-1:0]       req_addr_i
   , output logic [PROF_REGIONS-1:0] prof_bits_o
   , output logic [DATA_W-1:0]       viol_count_o
);

   logic [PROF_REGIONS-1:0] prof_r;
   logic [DATA_W-1:0]       viol_r;
   logic [PROF_IDX_W-1:0]   region_idx;
   logic                    over_limit;

   // one bit per 8 MiB region of the core address
   assign region_idx = req_addr_i[PROF_LSB +: PROF_IDX_W];
   assign over_limit = (req_addr_i ^ CORE_DRAM_BASE) >= MEM_LIMIT;

   // history only covers the current run of the core
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         prof_r <= '0;
         viol_r <= '0;
      end
      else if (core_reset_i)
      begin
         prof_r <= '0;
         viol_r <= '0;
      end
      else if (req_fire_i)
      begin
         if (int'(region_idx) < PROF_REGIONS)
            prof_r[region_idx] <= 1'b1;
         // counter sticks at all ones rather than wrapping
         if (over_limit && (viol_r != '1))
            viol_r <= viol_r + 1'b1;
      end
   end

   assign prof_bits_o  = prof_r;
   assign viol_count_o = viol_r;

endmodule

// File: hdl/addr_remap.sv
module addr_remap
   import bridge_pkg::*;
(
   input  logic                     aclk_i
   , input  logic                   arst_n_i
   , input  logic                   host_valid_i
   , input  logic [HOST_ADDR_W-1:0] host_addr_i
   , output logic                   host_ready_o
   , output logic                   core_valid_o
   , output logic [ADDR_W-1:0]      core_addr_o
   , input  logic                   core_ready_i
   , input  logic                   core_req_valid_i
   , input  logic [ADDR_W-1:0]      core_req_addr_i
   , input  dram_op_e               core_req_op_i
   , output logic                   core_req_ready_o
   , input  logic [ADDR_W-1:0]      dram_base_i
   , output logic                   fifo_valid_o
   , output logic [ADDR_W-1:0]      fifo_addr_o
   , output dram_op_e               fifo_op_o
   , input  logic                   fifo_ready_i
);

   logic              host_vld_r;
   logic [ADDR_W-1:0] host_addr_r;
   logic [ADDR_W-1:0] host_xlat;
   logic              req_vld_r;
   logic [ADDR_W-1:0] req_addr_r;
   dram_op_e          req_op_r;
   logic [ADDR_W-1:0] req_rebased;

   // host window 0x0xxx_xxxx lands on core DRAM, 0x2xxx_xxxx on core local space
   assign host_xlat = {~host_addr_i[29], 3'b000, host_addr_i[27:0]};

   // strip the core DRAM base and move into the region the host allocated
   assign req_rebased = (core_req_addr_i ^ CORE_DRAM_BASE) + dram_base_i;

   assign host_ready_o     = ~host_vld_r | core_ready_i;
   assign core_req_ready_o = ~req_vld_r | fifo_ready_i;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         host_vld_r <= 1'b0;
         req_vld_r  <= 1'b0;
      end
      else
      begin
         if (host_valid_i && host_ready_o)
            host_vld_r <= 1'b1;
         else if (core_ready_i)
            host_vld_r <= 1'b0;

         if (core_req_valid_i && core_req_ready_o)
            req_vld_r <= 1'b1;
         else if (fifo_ready_i)
            req_vld_r <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (host_valid_i && host_ready_o)
         host_addr_r <= host_xlat;
      // base is sampled here, later base writes do not affect this request
      if (core_req_valid_i && core_req_ready_o)
      begin
         req_addr_r <= req_rebased;
         req_op_r   <= core_req_op_i;
      end
   end

   assign core_valid_o = host_vld_r;
   assign core_addr_o  = host_addr_r;
   assign fifo_valid_o = req_vld_r;
   assign fifo_addr_o  = req_addr_r;
   assign fifo_op_o    = req_op_r;

endmodule

// File: hdl/shell_csr.sv
module shell_csr
   import bridge_pkg::*;
#(
   parameter int PROF_REGIONS = bridge_pkg::PROF_REGIONS
)
(
   input  logic                    aclk_i
   , input  logic                  arst_n_i
   , input  logic [APB_ADDR_W-1:0] paddr_i
   , input  logic                  psel_i
   , input  logic                  penable_i
   , input  logic                  pwrite_i
   , input  logic [DATA_W-1:0]     pwdata_i
   , output logic [DATA_W-1:0]     prdata_o
   , output logic                  pready_o
   , output logic                  pslverr_o
   , input  logic [PROF_REGIONS-1:0] prof_bits_i
   , input  logic [DATA_W-1:0]     viol_count_i
   , output logic [ADDR_W-1:0]     dram_base_o
   , output logic                  core_reset_o
);

   logic                  apb_access;
   logic                  apb_write;
   logic                  addr_mapped;
   logic                  addr_writable;
   logic [DATA_W-1:0]     rd_data;
   logic [4*DATA_W-1:0]   prof_ext;
   logic                  run_r;
   logic                  alloc_r;
   logic [ADDR_W-1:0]     base_r;

   // second phase of an APB transfer, no wait states are ever inserted
   assign apb_access = psel_i & penable_i;
   assign apb_write  = apb_access & pwrite_i;

   // the bitmap is read back as four words, unused upper bits read as zero
   always_comb
   begin
      prof_ext = '0;
      prof_ext[PROF_REGIONS-1:0] = prof_bits_i;
   end

   always_comb
   begin
      addr_mapped   = 1'b1;
      addr_writable = 1'b0;
      rd_data       = '0;
      case (csr_addr_e'(paddr_i))
         CSR_CTRL:
         begin
            addr_writable = 1'b1;
            rd_data[0]    = run_r;
         end
         CSR_ALLOC:
         begin
            addr_writable = 1'b1;
            rd_data[0]    = alloc_r;
         end
         CSR_BASE:
         begin
            addr_writable = 1'b1;
            rd_data       = base_r;
         end
         CSR_PROF0: rd_data = prof_ext[0*DATA_W +: DATA_W];
         CSR_PROF1: rd_data = prof_ext[1*DATA_W +: DATA_W];
         CSR_PROF2: rd_data = prof_ext[2*DATA_W +: DATA_W];
         CSR_PROF3: rd_data = prof_ext[3*DATA_W +: DATA_W];
         CSR_VIOL:  rd_data = viol_count_i;
         default:   addr_mapped = 1'b0;
      endcase
   end

   // writes to read-only or unmapped offsets are dropped and flagged
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_r   <= 1'b0;
         alloc_r <= 1'b0;
         base_r  <= '0;
      end
      else if (apb_write)
      begin
         case (csr_addr_e'(paddr_i))
            CSR_CTRL:  run_r   <= pwdata_i[0];
            CSR_ALLOC: alloc_r <= pwdata_i[0];
            CSR_BASE:  base_r  <= pwdata_i;
            default:   ;
         endcase
      end
   end

   assign prdata_o    = rd_data;
   assign pready_o    = 1'b1;
   assign pslverr_o   = apb_access & (~addr_mapped | (pwrite_i & ~addr_writable));
   assign dram_base_o = base_r;

   // the core can be restarted from the host without touching the bridge reset
   assign core_reset_o = ~run_r | ~arst_n_i;

endmodule

// File: hdl/bridge_pkg.sv
package bridge_pkg;

   // core and DRAM side addresses are full 32 bits
   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;

   // the host window port loses its top two address bits on the way in
   localparam int HOST_ADDR_W = 30;

   // byte addressed register block, eight words used
   localparam int APB_ADDR_W  = 6;

   // cached DRAM starts here in the core's physical map
   localparam logic [ADDR_W-1:0] CORE_DRAM_BASE = 32'h8000_0000;

   // offsets at or above this are outside the memory the host set aside (120 MiB)
   localparam logic [ADDR_W-1:0] MEM_LIMIT = 32'h0780_0000;

   // each profiler bit covers one 8 MiB region, index taken from bits 29..23
   localparam int PROF_REGIONS = 128;
   localparam int PROF_LSB     = 23;
   localparam int PROF_IDX_W   = 7;

   // register map as seen from the host, byte offsets
   typedef enum logic [APB_ADDR_W-1:0]
   {
      CSR_CTRL  = 6'd0,
      CSR_ALLOC = 6'd4,
      CSR_BASE  = 6'd8,
      CSR_PROF0 = 6'd12,
      CSR_PROF1 = 6'd16,
      CSR_PROF2 = 6'd20,
      CSR_PROF3 = 6'd24,
      CSR_VIOL  = 6'd28
   } csr_addr_e;

   // direction of a core DRAM request
   typedef enum logic
   {
      DRAM_RD = 1'b0,
      DRAM_WR = 1'b1
   } dram_op_e;

endpackage
